// ==== eeprom_cfg.svh ====
`ifndef EEPROM_CFG_SVH
`define EEPROM_CFG_SVH

// system clocks per quarter of an SCL bit
`define EEPROM_SCL_DIV 4

// 24Cxx device type, top nibble of the control byte
`define EEPROM_DEV_TYPE 4'b1010

// byte address width, A10..A8 travel as block bits
`define EEPROM_ADDR_W 11

`endif

// ==== eeprom_pkg.sv ====
`default_nettype none
`include "eeprom_cfg.svh"

package eeprom_pkg;

    // command operands, taken with the wr or rd strobe
    typedef struct packed {
        logic [`EEPROM_ADDR_W-1:0] addr;
        logic [7:0]                wdata;
    } eeprom_req_t;

    typedef enum logic [1:0] {
        SYM_START, // also used for the restart
        SYM_STOP,
        SYM_BIT
    } sym_kind_t;

    // one bus symbol, FSM to line driver
    typedef struct packed {
        sym_kind_t kind;
        logic      bit_val; // 1 releases sda
    } sym_cmd_t;

    // result of the last command
    typedef struct packed {
        logic [7:0] rdata;
        logic       nack;  // any missing slave ack
    } eeprom_rsp_t;

endpackage

`default_nettype wire

// ==== scl_timer.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "eeprom_cfg.svh"

module scl_timer #(
    parameter int DIV = `EEPROM_SCL_DIV
) (
    input  logic CLK,
    input  logic RESET,
    input  logic run,
    output logic qtick
);

    localparam int            CW     = (DIV > 1) ? $clog2(DIV) : 1;
    localparam logic [CW-1:0] RELOAD = CW'(DIV - 1);

    logic [CW-1:0] cnt;

    // down counter, parked at the reload value while idle
    always_ff @(posedge CLK) begin
        if (RESET || !run) begin
            cnt <= RELOAD; // so the first tick comes DIV clocks after run rises
        end else if (cnt == '0) begin
            cnt <= RELOAD;
        end else begin
            cnt <= cnt - 1'b1;
        end
    end

    assign qtick = run && (cnt == '0);

endmodule

`default_nettype wire

// ==== i2c_line_driver.sv ====
`timescale 1ns/10ps
`default_nettype none

module i2c_line_driver import eeprom_pkg::*; (
    input  logic     CLK,
    input  logic     RESET,
    input  logic     sym_go,
    input  sym_cmd_t sym,
    input  logic     qtick,
    output logic     run,
    output logic     sym_done,
    output logic     sda_sample,
    output logic     scl,
    output logic     sda_oe,
    input  logic     sda_in
);

    sym_cmd_t   cur;      // symbol on the wire
    logic [1:0] phase;
    logic [1:0] lv_first; // {scl, sda_oe} for phase 0 of a new symbol
    logic [1:0] lv_next;

    // line levels {scl, sda_oe} for one phase of a symbol
    function automatic logic [1:0] line_level(input sym_cmd_t s, input logic [1:0] ph,
                                               input logic scl_now);
        logic [1:0] lv;
        case (s.kind)
            SYM_START: begin
                case (ph)
                    2'd0:    lv = {scl_now, 1'b0}; // release sda, scl as it was
                    2'd1:    lv = 2'b10;
                    2'd2:    lv = 2'b11;           // sda falls while scl high
                    default: lv = 2'b01;
                endcase
            end
            SYM_STOP: begin
                case (ph)
                    2'd0:    lv = 2'b01;
                    2'd1:    lv = 2'b11;
                    default: lv = 2'b10;           // sda rises, bus left idle
                endcase
            end
            default: begin
                lv = {(ph == 2'd1) || (ph == 2'd2), ~s.bit_val};
            end
        endcase
        return lv;
    endfunction

    assign lv_first = line_level(sym, 2'd0, scl);
    assign lv_next  = line_level(cur, phase + 2'd1, scl);

    always_ff @(posedge CLK) begin
        if (RESET) begin
            run      <= 1'b0;
            phase    <= 2'd0;
            sym_done <= 1'b0;
            scl      <= 1'b1;
            sda_oe   <= 1'b0;
        end else begin
            sym_done <= 1'b0;
            if (!run) begin
                if (sym_go) begin
                    run           <= 1'b1;
                    phase         <= 2'd0;
                    {scl, sda_oe} <= lv_first;
                end
            end else if (qtick) begin
                if (phase == 2'd3) begin
                    run      <= 1'b0; // lines hold until the next symbol
                    sym_done <= 1'b1;
                end else begin
                    phase         <= phase + 2'd1;
                    {scl, sda_oe} <= lv_next;
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (!run && sym_go) begin
            cur <= sym;
        end
        if (run && qtick && (phase == 2'd1)) begin
            sda_sample <= sda_in; // middle of scl high
        end
    end

endmodule

`default_nettype wire

// ==== byte_shifter.sv ====
`timescale 1ns/10ps
`default_nettype none

module byte_shifter (
    input  logic       CLK,
    input  logic       RESET,
    input  logic       load,
    input  logic [7:0] din,
    input  logic       shift,
    input  logic       sda_sample,
    output logic       msb,
    output logic [7:0] dout
);

    // one register for both directions, MSB first on the wire
    logic [7:0] sr;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            sr <= 8'h00;
        end else if (load) begin
            sr <= din;
        end else if (shift) begin
            sr <= {sr[6:0], sda_sample}; // received bits enter at the LSB
        end
    end

    assign msb  = sr[7];
    assign dout = sr;

endmodule

`default_nettype wire

// ==== eeprom_ctrl_fsm.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "eeprom_cfg.svh"

module eeprom_ctrl_fsm import eeprom_pkg::*; (
    input  logic        CLK,
    input  logic        RESET,
    input  logic        wr,
    input  logic        rd,
    input  eeprom_req_t req,
    output logic        busy,
    output logic        done,
    output eeprom_rsp_t rsp,
    output logic        sym_go,
    output sym_cmd_t    sym,
    input  logic        sym_done,
    input  logic        sda_sample,
    output logic        load,
    output logic [7:0]  din,
    output logic        shift,
    input  logic        msb,
    input  logic [7:0]  dout
);

    typedef enum logic [3:0] {
        IDLE, START, CTRL_W, ADDR, DATA_W, RESTART,
        CTRL_R, DATA_R, MNACK, STOP, FINISH
    } state_t;

    state_t      state;
    eeprom_req_t req_q;
    logic        is_read;
    logic [3:0]  bit_cnt;   // 8 data bits then the ack
    logic        in_flight; // symbol handed to the line driver
    logic        nack_acc;
    logic [7:0]  rdata_q;
    logic        take;
    logic        tx_byte;
    logic        ack_bit;

    assign take    = !busy && (wr || rd);
    assign tx_byte = (state == CTRL_W) || (state == ADDR) || (state == DATA_W) ||
                     (state == CTRL_R);
    assign ack_bit = tx_byte && (bit_cnt == 4'd8);

    assign sym_go = (state != IDLE) && (state != FINISH) && !in_flight;

    always_comb begin
        sym.kind    = SYM_BIT;
        sym.bit_val = 1'b1; // released, read data and master nack
        case (state)
            START, RESTART:               sym.kind = SYM_START;
            STOP:                         sym.kind = SYM_STOP;
            CTRL_W, ADDR, DATA_W, CTRL_R: sym.bit_val = ack_bit ? 1'b1 : msb;
            default: ;
        endcase
    end

    // next byte to send, loaded as the previous symbol ends
    always_comb begin
        case (state)
            START:   din = {`EEPROM_DEV_TYPE, req_q.addr[`EEPROM_ADDR_W-1:8], 1'b0};
            CTRL_W:  din = req_q.addr[7:0];
            ADDR:    din = req_q.wdata;
            RESTART: din = {`EEPROM_DEV_TYPE, req_q.addr[`EEPROM_ADDR_W-1:8], 1'b1};
            default: din = 8'h00;
        endcase
    end

    assign load  = sym_done && ((state == START) || (state == RESTART) ||
                   (ack_bit && ((state == CTRL_W) || ((state == ADDR) && !is_read))));
    assign shift = sym_done && ((tx_byte && !ack_bit) || (state == DATA_R));

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state     <= IDLE;
            bit_cnt   <= 4'd0;
            in_flight <= 1'b0;
            busy      <= 1'b0;
            done      <= 1'b0;
            is_read   <= 1'b0;
            nack_acc  <= 1'b0;
        end else begin
            done <= 1'b0;
            if (sym_go) begin
                in_flight <= 1'b1;
            end
            if (sym_done) begin
                in_flight <= 1'b0;
            end
            case (state)
                IDLE, FINISH: begin
                    state <= IDLE;
                    if (take) begin
                        state    <= START;
                        busy     <= 1'b1;
                        is_read  <= !wr; // wr wins
                        nack_acc <= 1'b0;
                        bit_cnt  <= 4'd0;
                    end
                end
                START: begin
                    if (sym_done) state <= CTRL_W;
                end
                RESTART: begin
                    if (sym_done) state <= CTRL_R;
                end
                CTRL_W, ADDR, DATA_W, CTRL_R: begin
                    if (sym_done && ack_bit) begin
                        bit_cnt  <= 4'd0;
                        nack_acc <= nack_acc | sda_sample; // high means no ack
                        case (state)
                            CTRL_W:  state <= ADDR;
                            ADDR:    state <= is_read ? RESTART : DATA_W;
                            DATA_W:  state <= STOP;
                            default: state <= DATA_R;
                        endcase
                    end else if (sym_done) begin
                        bit_cnt <= bit_cnt + 4'd1;
                    end
                end
                DATA_R: begin
                    if (sym_done && (bit_cnt == 4'd7)) begin
                        bit_cnt <= 4'd0;
                        state   <= MNACK;
                    end else if (sym_done) begin
                        bit_cnt <= bit_cnt + 4'd1;
                    end
                end
                MNACK: begin
                    if (sym_done) state <= STOP;
                end
                STOP: begin
                    if (sym_done) begin
                        state <= FINISH;
                        busy  <= 1'b0;
                        done  <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (take) begin
            req_q <= req;
        end
        if ((state == MNACK) && sym_done) begin
            rdata_q <= dout; // whole byte shifted in by now
        end
        if ((state == STOP) && sym_done) begin
            rsp.rdata <= rdata_q;
            rsp.nack  <= nack_acc;
        end
    end

endmodule

`default_nettype wire

// ==== eeprom_wr.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "eeprom_cfg.svh"

module eeprom_wr import eeprom_pkg::*; (
    input  logic        CLK,
    input  logic        RESET,
    input  logic        wr,
    input  logic        rd,
    input  eeprom_req_t req,
    output logic        busy,
    output logic        done,
    output eeprom_rsp_t rsp,
    output logic        scl,
    output logic        sda_oe,
    input  logic        sda_in
);

    logic       qtick;
    logic       run;
    logic       sym_go;
    sym_cmd_t   sym;
    logic       sym_done;
    logic       sda_sample;
    logic       load;
    logic [7:0] din;
    logic       shift;
    logic       msb;
    logic [7:0] dout;

    scl_timer #(
        .DIV (`EEPROM_SCL_DIV)
    ) i_timer (
        .CLK   (CLK),
        .RESET (RESET),
        .run   (run),
        .qtick (qtick)
    );

    i2c_line_driver i_line (
        .CLK        (CLK),
        .RESET      (RESET),
        .sym_go     (sym_go),
        .sym        (sym),
        .qtick      (qtick),
        .run        (run),
        .sym_done   (sym_done),
        .sda_sample (sda_sample),
        .scl        (scl),
        .sda_oe     (sda_oe),
        .sda_in     (sda_in)
    );

    byte_shifter i_shift (
        .CLK        (CLK),
        .RESET      (RESET),
        .load       (load),
        .din        (din),
        .shift      (shift),
        .sda_sample (sda_sample),
        .msb        (msb),
        .dout       (dout)
    );

    eeprom_ctrl_fsm i_fsm (
        .CLK        (CLK),
        .RESET      (RESET),
        .wr         (wr),
        .rd         (rd),
        .req        (req),
        .busy       (busy),
        .done       (done),
        .rsp        (rsp),
        .sym_go     (sym_go),
        .sym        (sym),
        .sym_done   (sym_done),
        .sda_sample (sda_sample),
        .load       (load),
        .din        (din),
        .shift      (shift),
        .msb        (msb),
        .dout       (dout)
    );

endmodule

`default_nettype wire

// ==== eeprom_model.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "eeprom_cfg.svh"

module eeprom_model (
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic sda,      // wired-AND bus level
    input  logic absent,   // device does not answer
    output logic sda_pull  // high pulls sda low
);

    typedef enum logic [2:0] {
        M_IDLE, M_CTRL, M_ADDR, M_WDATA, M_RDATA, M_IGNORE
    } mode_t;

    logic [7:0]  mem [0:2047];
    mode_t       mode;
    logic        scl_q;
    logic        sda_q;
    logic [3:0]  bit_cnt;
    logic        ack_phase;
    logic        rd_next;
    logic [2:0]  block;
    logic [10:0] ptr;
    logic [7:0]  shreg;
    logic        start_c;
    logic        stop_c;
    logic        rise;
    logic        fall;
    logic        byte_end;

    initial begin
        for (int i = 0; i < 2048; i++) begin
            mem[i] = 8'(i ^ (i >> 3)); // every address bit shows up
        end
    end

    assign start_c  = scl && scl_q && sda_q && !sda;
    assign stop_c   = scl && scl_q && !sda_q && sda;
    assign rise     = scl && !scl_q;
    assign fall     = !scl && scl_q;
    assign byte_end = fall && !ack_phase && (bit_cnt == 4'd8);

    always_ff @(posedge CLK) begin
        scl_q <= scl;
        sda_q <= sda;
        if (RESET) begin
            mode      <= M_IDLE;
            sda_pull  <= 1'b0;
            bit_cnt   <= 4'd0;
            ack_phase <= 1'b0;
            rd_next   <= 1'b0;
            block     <= 3'd0;
            ptr       <= 11'd0;
            shreg     <= 8'h00;
        end else if (start_c) begin
            mode      <= absent ? M_IGNORE : M_CTRL;
            bit_cnt   <= 4'd0;
            ack_phase <= 1'b0;
            sda_pull  <= 1'b0;
        end else if (stop_c) begin
            mode     <= M_IDLE;
            sda_pull <= 1'b0;
        end else if ((mode != M_IDLE) && (mode != M_IGNORE)) begin
            if (rise && !ack_phase && (bit_cnt != 4'd8)) begin
                bit_cnt <= bit_cnt + 4'd1;
                if (mode != M_RDATA) begin
                    shreg <= {shreg[6:0], sda};
                end
            end else if (fall && ack_phase) begin
                ack_phase <= 1'b0;
                bit_cnt   <= 4'd0;
                sda_pull  <= 1'b0;
                if (mode == M_RDATA) begin
                    mode <= M_IGNORE; // single byte reads only
                end else if (rd_next) begin
                    mode     <= M_RDATA;
                    shreg    <= mem[ptr];
                    sda_pull <= ~mem[ptr][7];
                end
            end else if (byte_end) begin
                ack_phase <= 1'b1;
                sda_pull  <= 1'b1;
                case (mode)
                    M_CTRL: begin
                        if (shreg[7:4] == `EEPROM_DEV_TYPE) begin
                            block   <= shreg[3:1];
                            rd_next <= shreg[0];
                            mode    <= shreg[0] ? M_CTRL : M_ADDR;
                        end else begin
                            mode     <= M_IGNORE;
                            sda_pull <= 1'b0;
                        end
                    end
                    M_ADDR: begin
                        ptr  <= {block, shreg};
                        mode <= M_WDATA;
                    end
                    M_WDATA: ptr <= ptr + 11'd1;
                    default: sda_pull <= 1'b0; // master ack or nack slot
                endcase
            end else if (fall && (mode == M_RDATA)) begin
                shreg    <= {shreg[6:0], 1'b0};
                sda_pull <= ~shreg[6];
            end
        end
    end

    always @(posedge CLK) begin
        if (!RESET && !start_c && !stop_c && byte_end && (mode == M_WDATA)) begin
            mem[ptr] <= shreg;
        end
    end

endmodule

`default_nettype wire

// ==== tb_eeprom_wr.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "eeprom_cfg.svh"

module tb_eeprom_wr import eeprom_pkg::*; ();

    localparam int LIMIT = 2 * 40 * 4 * `EEPROM_SCL_DIV; // a read is 39 symbols plus hand-off

    logic        CLK;
    logic        RESET;
    logic        wr;
    logic        rd;
    eeprom_req_t req;
    logic        busy;
    logic        done;
    eeprom_rsp_t rsp;
    logic        scl;
    logic        sda_oe;
    logic        sda;
    logic        slave_pull;
    logic        absent;
    logic        scl_q;
    logic        sda_q;
    logic        high_chg;    // sda already moved in this scl high period
    logic        chk_rd;
    logic [7:0]  exp_rdata;
    logic        exp_nack;
    logic [15:0] lfsr = 16'd46732;
    logic [7:0]  shadow [0:2047];
    logic        timed_out;
    int          n_err;
    int          n_acc;
    int          n_done;

    assign sda = ~sda_oe & ~slave_pull;

    eeprom_wr i_dut (
        .CLK(CLK), .RESET(RESET), .wr(wr), .rd(rd), .req(req),
        .busy(busy), .done(done), .rsp(rsp),
        .scl(scl), .sda_oe(sda_oe), .sda_in(sda)
    );

    eeprom_model i_slave (
        .CLK(CLK), .RESET(RESET), .scl(scl), .sda(sda),
        .absent(absent), .sda_pull(slave_pull)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        scl_q <= scl;
        sda_q <= sda;
        if (RESET) begin
            n_acc    <= 0;
            n_done   <= 0;
            high_chg <= 1'b0;
        end else begin
            if (!busy && (wr || rd)) n_acc <= n_acc + 1;
            if (done) n_done <= n_done + 1;
            if (!scl || !busy) begin
                high_chg <= 1'b0;
            end else if (scl_q && (sda != sda_q)) begin
                high_chg <= 1'b1;
            end
        end
    end

    a_reset: assert property (@(posedge CLK) $fell(RESET) |-> scl && !sda_oe && !busy && !done)
        else begin
            n_err = n_err + 1;
            $display("Fail: %0t idle bus after reset, scl %b sda_oe %b busy %b done %b",
                     $time, scl, sda_oe, busy, done);
        end
    a_take: assert property (@(posedge CLK) disable iff (RESET) (!busy && (wr || rd)) |=> busy)
        else begin
            n_err = n_err + 1;
            $display("Fail: %0t busy got %b expected 1", $time, busy);
        end
    a_busy_end: assert property (@(posedge CLK) disable iff (RESET) $fell(busy) |-> done)
        else begin
            n_err = n_err + 1;
            $display("Fail: %0t done got %b expected 1", $time, done);
        end
    a_rdata: assert property (@(posedge CLK) disable iff (RESET)
                              (done && chk_rd) |-> rsp.rdata == exp_rdata)
        else begin
            n_err = n_err + 1;
            $display("Fail: %0t rsp.rdata got %h expected %h", $time, rsp.rdata, exp_rdata);
        end
    a_nack: assert property (@(posedge CLK) disable iff (RESET) done |-> rsp.nack == exp_nack)
        else begin
            n_err = n_err + 1;
            $display("Fail: %0t rsp.nack got %b expected %b", $time, rsp.nack, exp_nack);
        end
    a_release: assert property (@(posedge CLK) disable iff (RESET) done |-> scl && !sda_oe)
        else begin
            n_err = n_err + 1;
            $display("Fail: %0t bus not released, scl %b sda_oe %b", $time, scl, sda_oe);
        end
    a_one_done: assert property (@(posedge CLK) disable iff (RESET) done |-> n_acc == n_done + 1)
        else begin
            n_err = n_err + 1;
            $display("Fail: %0t done count got %0d expected %0d", $time, n_done + 1, n_acc);
        end
    a_sda_rule: assert property (@(posedge CLK) disable iff (RESET)
                                 (scl && scl_q && (sda != sda_q)) |-> busy && !high_chg)
        else begin
            n_err = n_err + 1;
            $display("sda changed while scl high outside a start or stop at %0t", $time);
        end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic get_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[14:0], lfsr[15]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    task automatic strobe(input logic is_wr, input logic [10:0] a, input logic [7:0] d);
        @(posedge CLK);
        #1;
        req.addr  = a;
        req.wdata = d;
        wr        = is_wr;
        rd        = !is_wr;
        @(posedge CLK);
        #1;
        wr = 1'b0;
        rd = 1'b0;
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (!done && (n < LIMIT) && !timed_out) begin
            @(posedge CLK);
            #1;
            n++;
        end
        if (done) begin
            @(posedge CLK); // done cycle is checked at this edge
            #1;
        end else if (!timed_out) begin
            timed_out = 1'b1;
            $display("timed out waiting for done at %0t", $time);
        end
    endtask

    // write, then update the shadow copy
    task automatic write_byte(input logic [10:0] a, input logic [7:0] d, input logic nk);
        if (!timed_out) begin
            chk_rd   = 1'b0;
            exp_nack = nk;
            strobe(1'b1, a, d);
            wait_done();
            if (!nk) shadow[a] = d;
        end
    endtask

    task automatic read_byte(input logic [10:0] a, input logic chk, input logic nk);
        if (!timed_out) begin
            chk_rd    = chk;
            exp_rdata = shadow[a];
            exp_nack  = nk;
            strobe(1'b0, a, 8'h00);
            wait_done();
        end
    endtask

    initial begin
        logic [15:0] r;
        logic [10:0] a1;
        logic [10:0] a2;
        logic [7:0]  d1;
        logic [7:0]  d2;
        logic [10:0] addrs [0:7];
        RESET     = 1'b1;
        wr        = 1'b0;
        rd        = 1'b0;
        req       = '0;
        absent    = 1'b0;
        chk_rd    = 1'b0;
        exp_rdata = 8'h00;
        exp_nack  = 1'b0;
        timed_out = 1'b0;
        n_err     = 0;
        repeat (2) @(posedge CLK);
        #1;
        RESET = 1'b0;

        for (int i = 0; i < 8; i++) begin // one address per block
            get_bits(8, r);
            addrs[i] = {3'(i), r[7:0]};
            get_bits(8, r);
            write_byte(addrs[i], r[7:0], 1'b0);
            read_byte(addrs[i], 1'b1, 1'b0);
        end

        get_bits(8, r);
        a1 = {3'b010, r[7:0]};
        a2 = {3'b101, r[7:0]};
        get_bits(8, r);
        d1 = r[7:0];
        get_bits(8, r);
        d2 = (r[7:0] == d1) ? ~d1 : r[7:0];
        write_byte(a1, d1, 1'b0);
        write_byte(a2, d2, 1'b0);
        read_byte(a1, 1'b1, 1'b0);
        read_byte(a2, 1'b1, 1'b0);

        absent = 1'b1;
        write_byte(a1, 8'h3c, 1'b1);
        read_byte(a1, 1'b0, 1'b1);
        absent = 1'b0;

        // wr strobe during a read must be dropped
        if (!timed_out) begin
            chk_rd    = 1'b1;
            exp_rdata = shadow[addrs[3]];
            exp_nack  = 1'b0;
            strobe(1'b0, addrs[3], 8'h00);
            strobe(1'b1, a1, ~d1);
            wait_done();
        end
        read_byte(a1, 1'b1, 1'b0);
        repeat (4) @(posedge CLK);

        $display("errors: %0d check failures, %0d timeouts", n_err, timed_out ? 1 : 0);
        if ((n_err == 0) && !timed_out) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== eeprom_wr.f ====
+incdir+.
eeprom_pkg.sv
scl_timer.sv
i2c_line_driver.sv
byte_shifter.sv
eeprom_ctrl_fsm.sv
eeprom_wr.sv
eeprom_model.sv
tb_eeprom_wr.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_eeprom_wr
FLIST     ?= eeprom_wr.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FLIST)) eeprom_cfg.svh
BIN  := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
